// File: logic/lc3b_defines.svh
`ifndef LC3B_DEFINES_SVH
`define LC3B_DEFINES_SVH

// instruction word and address width
`define LC3B_WORD_WIDTH 16

// barrier slots between fetch and EX/MEM
`define BR_QUEUE_DEPTH 3

// byte step to the next instruction
`define PC_STEP 2

// BR offset field width in the instruction word
`define BR_OFFSET_WIDTH 9

// opcode field position
`define OPCODE_MSB 15
`define OPCODE_LSB 12

`endif

// File: logic/lc3b_types.sv
`include "lc3b_defines.svh"

package lc3b_types;

    // instruction or address
    typedef logic [`LC3B_WORD_WIDTH-1:0] lc3b_word;

    // raw PC-relative offset of a BR
    typedef logic [`BR_OFFSET_WIDTH-1:0] lc3b_offset9;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    // next-PC sources, in pc mux input order
    typedef enum logic [2:0] {
        lc3b_pc_mux_sel_pc_plus2           = 3'd0,
        lc3b_pc_mux_sel_alu                = 3'd1,
        lc3b_pc_mux_sel_pcn                = 3'd2,
        lc3b_pc_mux_sel_mdr                = 3'd3,
        lc3b_pc_mux_sel_branch_address     = 3'd4,
        lc3b_pc_mux_sel_mispredict_address = 3'd5
    } lc3b_pc_mux_sel;

endpackage : lc3b_types

// File: logic/branch_fetch_decode.sv
`timescale 1ns/10ps
`include "lc3b_defines.svh"

module branch_fetch_decode
    import lc3b_types::*;
(
    input  lc3b_word if_ir,
    input  lc3b_word if_pc,
    input  logic     if_valid,
    input  logic     branch_prediction,

    output lc3b_word pc_plus2,
    output lc3b_word branch_address,
    output logic     fetch_redirect,
    output logic     load_prediction,
    output logic     prediction_in,
    output lc3b_word mispredict_address_in
);

    lc3b_opcode  if_opcode;
    lc3b_offset9 offset9;
    lc3b_word    offset_sext;
    logic        is_br;

    assign if_opcode = lc3b_opcode'(if_ir[`OPCODE_MSB:`OPCODE_LSB]);
    assign offset9   = if_ir[`BR_OFFSET_WIDTH-1:0];

    // sign extend, then word align
    assign offset_sext = {{(`LC3B_WORD_WIDTH-`BR_OFFSET_WIDTH-1){offset9[`BR_OFFSET_WIDTH-1]}},
                          offset9, 1'b0};

    assign pc_plus2       = if_pc + lc3b_word'(`PC_STEP);
    assign branch_address = pc_plus2 + offset_sext;

    assign is_br = if_valid && (if_opcode == op_br);

    // taken prediction steers fetch to the target
    assign fetch_redirect = is_br && branch_prediction;

    always_comb begin
        load_prediction       = 1'b0;
        prediction_in         = 1'b0;
        mispredict_address_in = '0;

        if (is_br) begin
            load_prediction = 1'b1;
            prediction_in   = branch_prediction;

            // keep the path we did not follow
            if (branch_prediction) begin
                mispredict_address_in = pc_plus2;
            end else begin
                mispredict_address_in = branch_address;
            end
        end
    end

endmodule : branch_fetch_decode

// File: logic/branch_waterfall_queue.sv
`timescale 1ns/10ps
`include "lc3b_defines.svh"

module branch_waterfall_queue
    import lc3b_types::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,
    input  logic     flush,

    input  logic     load_prediction,
    input  logic     prediction_in,
    input  lc3b_word mispredict_address_in,

    output logic     head_valid,
    output logic     prediction_out,
    output lc3b_word mispredict_address_out
);

    localparam int DEPTH = `BR_QUEUE_DEPTH;

    // slot 0 is the head, facing EX/MEM
    logic [DEPTH-1:0] valid_q;
    logic [DEPTH-1:0] pred_q;
    lc3b_word         addr_q [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (flush) begin
            // everything younger than EX/MEM is squashed
            valid_q <= '0;
        end else if (!stall) begin
            valid_q <= {load_prediction, valid_q[DEPTH-1:1]};
        end
    end

    // payload follows the valid bits
    always_ff @(posedge clk) begin
        if (!stall) begin
            for (int i = 0; i < DEPTH - 1; i++) begin
                pred_q[i] <= pred_q[i+1];
                addr_q[i] <= addr_q[i+1];
            end
            pred_q[DEPTH-1] <= prediction_in;
            addr_q[DEPTH-1] <= mispredict_address_in;
        end
    end

    assign head_valid             = valid_q[0];
    assign prediction_out         = pred_q[0];
    assign mispredict_address_out = addr_q[0];

    // a flush leaves the queue empty, even with stall or a new load pending
    flush_wins_over_stall_and_load: assert property (
        @(posedge clk) disable iff (rst)
        (flush && stall) || (flush && load_prediction) |=> (valid_q == '0)
    ) else $error("branch queue kept an entry across a flush");

endmodule : branch_waterfall_queue

// File: logic/branch_resolve.sv
`timescale 1ns/10ps

module branch_resolve
    import lc3b_types::*;
(
    input  logic       clk,

    input  lc3b_opcode ex_mem_opcode,
    input  logic       ex_mem_valid,
    input  logic       mem_br_en,

    input  logic       head_valid,
    input  logic       prediction_out,

    input  lc3b_opcode mem_wb_opcode,
    input  logic       mem_wb_valid,

    output logic       update_predictions,
    output logic       correct_prediction,
    output logic       mispredict,
    output logic       ex_redirect,
    output logic       trap_ex,
    output logic       trap_wb
);

    logic br_ex;
    logic jmp_ex;
    logic jsr_ex;
    logic hit;

    assign br_ex  = ex_mem_valid && (ex_mem_opcode == op_br);
    assign jmp_ex = ex_mem_valid && (ex_mem_opcode == op_jmp);
    assign jsr_ex = ex_mem_valid && (ex_mem_opcode == op_jsr);

    // taken or not taken, did we guess right
    assign hit = (prediction_out == mem_br_en);

    always_comb begin
        update_predictions = 1'b0;
        correct_prediction = 1'b0;
        mispredict         = 1'b0;

        if (br_ex) begin
            update_predictions = 1'b1;
            correct_prediction = hit;
            mispredict         = !hit;
        end
    end

    // indirect jumps resolve in EX/MEM
    assign ex_redirect = jmp_ex || jsr_ex;

    assign trap_ex = ex_mem_valid && (ex_mem_opcode == op_trap);
    assign trap_wb = mem_wb_valid && (mem_wb_opcode == op_trap);

    // the queue must stay in step with the barriers
    br_has_queue_entry: assert property (
        @(posedge clk) br_ex |-> head_valid
    ) else $error("BR reached EX/MEM with no recorded prediction");

endmodule : branch_resolve

// File: logic/branch_controller.sv
`timescale 1ns/10ps

module branch_controller
    import lc3b_types::*;
(
    input  logic           clk,

    input  logic           fetch_redirect,
    input  lc3b_word       pc_plus2,
    input  lc3b_word       branch_address,
    input  lc3b_word       mispredict_address_out,
    input  lc3b_word       ex_mem_alu,
    input  lc3b_word       ex_mem_pcn,
    input  lc3b_word       mem_wb_mdr,
    input  lc3b_pc_mux_sel ex_mem_pc_mux_sel,
    input  lc3b_pc_mux_sel mem_wb_pc_mux_sel,

    input  logic           update_predictions,
    input  logic           correct_prediction,
    input  logic           mispredict,
    input  logic           ex_redirect,
    input  logic           trap_ex,
    input  logic           trap_wb,

    output lc3b_word       pc_out,
    output logic           flush_active,
    output logic           flush_if_id,
    output logic           flush_id_ex,
    output logic           flush_ex_mem,
    output logic           flush_mem_wb,
    output logic           prediction_correct,
    output logic           prediction_incorrect
);

    lc3b_pc_mux_sel pc_mux_sel;
    logic           flush_front;

    // later checks override earlier ones, lowest priority first
    always_comb begin
        pc_mux_sel           = lc3b_pc_mux_sel_pc_plus2;
        flush_front          = 1'b0;
        flush_mem_wb         = 1'b0;
        prediction_correct   = 1'b0;
        prediction_incorrect = 1'b0;

        if (fetch_redirect) begin
            pc_mux_sel = lc3b_pc_mux_sel_branch_address;
        end

        if (update_predictions) begin
            prediction_correct   = correct_prediction;
            prediction_incorrect = mispredict;
            if (correct_prediction) begin
                pc_mux_sel = lc3b_pc_mux_sel_pc_plus2;
            end
        end

        if (mispredict) begin
            pc_mux_sel  = lc3b_pc_mux_sel_mispredict_address;
            flush_front = 1'b1;
        end

        if (ex_redirect) begin
            pc_mux_sel  = ex_mem_pc_mux_sel;
            flush_front = 1'b1;
        end

        // trap vector is only known once it reaches MEM/WB
        if (trap_ex) begin
            flush_front = 1'b1;
        end

        if (trap_wb) begin
            pc_mux_sel   = mem_wb_pc_mux_sel;
            flush_front  = 1'b1;
            flush_mem_wb = 1'b1;
        end
    end

    always_comb begin
        case (pc_mux_sel)
            lc3b_pc_mux_sel_alu:                pc_out = ex_mem_alu;
            lc3b_pc_mux_sel_pcn:                pc_out = ex_mem_pcn;
            lc3b_pc_mux_sel_mdr:                pc_out = mem_wb_mdr;
            lc3b_pc_mux_sel_branch_address:     pc_out = branch_address;
            lc3b_pc_mux_sel_mispredict_address: pc_out = mispredict_address_out;
            default:                            pc_out = pc_plus2;
        endcase
    end

    assign flush_active = flush_front;
    assign flush_if_id  = flush_front;
    assign flush_id_ex  = flush_front;
    assign flush_ex_mem = flush_front;

    strobes_exclusive: assert property (
        @(posedge clk) !(prediction_correct && prediction_incorrect)
    ) else $error("correct and incorrect prediction strobes together");

endmodule : branch_controller

// File: logic/branch_unit_top.sv
`timescale 1ns/10ps

module branch_unit_top
    import lc3b_types::*;
(
    input  logic           clk,
    input  logic           rst,
    input  logic           stall,
    input  logic           branch_prediction,

    input  lc3b_word       if_ir,
    input  lc3b_word       if_pc,
    input  logic           if_valid,

    input  lc3b_word       ex_mem_alu,
    input  lc3b_word       ex_mem_pcn,
    input  lc3b_pc_mux_sel ex_mem_pc_mux_sel,
    input  lc3b_opcode     ex_mem_opcode,
    input  logic           ex_mem_valid,

    input  logic           mem_br_en,

    input  lc3b_word       mem_wb_mdr,
    input  lc3b_pc_mux_sel mem_wb_pc_mux_sel,
    input  lc3b_opcode     mem_wb_opcode,
    input  logic           mem_wb_valid,

    output lc3b_word       pc_out,
    output lc3b_word       pc_plus2_out,
    output logic           flush_active,
    output logic           flush_if_id,
    output logic           flush_id_ex,
    output logic           flush_ex_mem,
    output logic           flush_mem_wb,
    output logic           prediction_correct,
    output logic           prediction_incorrect
);

    lc3b_word branch_address;
    logic     fetch_redirect;
    logic     load_prediction;
    logic     prediction_in;
    lc3b_word mispredict_address_in;

    logic     head_valid;
    logic     prediction_out;
    lc3b_word mispredict_address_out;

    logic     update_predictions;
    logic     correct_prediction;
    logic     mispredict;
    logic     ex_redirect;
    logic     trap_ex;
    logic     trap_wb;

    branch_fetch_decode u_fetch_decode (
        .if_ir,
        .if_pc,
        .if_valid,
        .branch_prediction,
        .pc_plus2 (pc_plus2_out),
        .branch_address,
        .fetch_redirect,
        .load_prediction,
        .prediction_in,
        .mispredict_address_in
    );

    // queue is squashed with the EX/MEM barrier
    branch_waterfall_queue u_queue (
        .clk,
        .rst,
        .stall,
        .flush (flush_ex_mem),
        .load_prediction,
        .prediction_in,
        .mispredict_address_in,
        .head_valid,
        .prediction_out,
        .mispredict_address_out
    );

    branch_resolve u_resolve (
        .clk,
        .ex_mem_opcode,
        .ex_mem_valid,
        .mem_br_en,
        .head_valid,
        .prediction_out,
        .mem_wb_opcode,
        .mem_wb_valid,
        .update_predictions,
        .correct_prediction,
        .mispredict,
        .ex_redirect,
        .trap_ex,
        .trap_wb
    );

    branch_controller u_controller (
        .clk,
        .fetch_redirect,
        .pc_plus2 (pc_plus2_out),
        .branch_address,
        .mispredict_address_out,
        .ex_mem_alu,
        .ex_mem_pcn,
        .mem_wb_mdr,
        .ex_mem_pc_mux_sel,
        .mem_wb_pc_mux_sel,
        .update_predictions,
        .correct_prediction,
        .mispredict,
        .ex_redirect,
        .trap_ex,
        .trap_wb,
        .pc_out,
        .flush_active,
        .flush_if_id,
        .flush_id_ex,
        .flush_ex_mem,
        .flush_mem_wb,
        .prediction_correct,
        .prediction_incorrect
    );

endmodule : branch_unit_top

// File: tests/tb_branch_unit.sv
`timescale 1ns/10ps

module tb_branch_unit
    import lc3b_types::*;
();

    localparam int MAX_LINES = 200;
    localparam int NUM_COLS  = 24;

    logic           clk;
    logic           rst;
    logic           stall;
    logic           branch_prediction;
    lc3b_word       if_ir;
    lc3b_word       if_pc;
    logic           if_valid;
    lc3b_word       ex_mem_alu;
    lc3b_word       ex_mem_pcn;
    lc3b_pc_mux_sel ex_mem_pc_mux_sel;
    lc3b_opcode     ex_mem_opcode;
    logic           ex_mem_valid;
    logic           mem_br_en;
    lc3b_word       mem_wb_mdr;
    lc3b_pc_mux_sel mem_wb_pc_mux_sel;
    lc3b_opcode     mem_wb_opcode;
    logic           mem_wb_valid;

    lc3b_word       pc_out;
    lc3b_word       pc_plus2_out;
    logic           flush_active;
    logic           flush_if_id;
    logic           flush_id_ex;
    logic           flush_ex_mem;
    logic           flush_mem_wb;
    logic           prediction_correct;
    logic           prediction_incorrect;

    // one stimulus line, inputs first, then expected outputs
    logic [15:0] col [NUM_COLS];

    string test_name;
    int    test_cycles;
    int    test_errors;
    int    tests_run;
    int    total_cycles;
    int    checks;
    int    errors;

    branch_unit_top u_dut (.*);

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    task automatic compare_value(input string sig, input logic [15:0] expected,
                                 input logic [15:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("FAILED %0t %s expected %h actual %h", $time, sig, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic apply_inputs();
        stall             = col[0][0];
        branch_prediction = col[1][0];
        if_ir             = col[2];
        if_pc             = col[3];
        if_valid          = col[4][0];
        ex_mem_alu        = col[5];
        ex_mem_pcn        = col[6];
        ex_mem_pc_mux_sel = lc3b_pc_mux_sel'(col[7][2:0]);
        ex_mem_opcode     = lc3b_opcode'(col[8][3:0]);
        ex_mem_valid      = col[9][0];
        mem_br_en         = col[10][0];
        mem_wb_mdr        = col[11];
        mem_wb_pc_mux_sel = lc3b_pc_mux_sel'(col[12][2:0]);
        mem_wb_opcode     = lc3b_opcode'(col[13][3:0]);
        mem_wb_valid      = col[14][0];
    endtask

    task automatic check_outputs();
        compare_value("pc_out", col[15], pc_out);
        compare_value("pc_plus2_out", col[16], pc_plus2_out);
        compare_value("flush_active", col[17], 16'(flush_active));
        compare_value("flush_if_id", col[18], 16'(flush_if_id));
        compare_value("flush_id_ex", col[19], 16'(flush_id_ex));
        compare_value("flush_ex_mem", col[20], 16'(flush_ex_mem));
        compare_value("flush_mem_wb", col[21], 16'(flush_mem_wb));
        compare_value("prediction_correct", col[22], 16'(prediction_correct));
        compare_value("prediction_incorrect", col[23], 16'(prediction_incorrect));
    endtask

    // entered 2 ns after a rising edge, left at the same point one cycle on
    task automatic run_cycle();
        apply_inputs();
        #16;
        check_outputs();
        test_cycles++;
        total_cycles++;
        @(posedge clk);
        #2;
    endtask

    task automatic report_test();
        $display("test %s: %0d cycles, %0d mismatches", test_name, test_cycles, test_errors);
        tests_run++;
    endtask

    task automatic handle_line(input string line, input int line_no);
        string name;
        int    n;
        if (line.len() > 0 && line.getc(0) == "#") begin
            if ($sscanf(line, "# test %s", name) == 1) begin
                if (test_name != "") begin
                    report_test();
                end
                test_name   = name;
                test_cycles = 0;
                test_errors = 0;
            end
        end else begin
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                        col[8], col[9], col[10], col[11], col[12], col[13], col[14], col[15],
                        col[16], col[17], col[18], col[19], col[20], col[21], col[22], col[23]);
            if (n == NUM_COLS) begin
                run_cycle();
            end else if (n > 0) begin
                $display("line %0d of the stimulus file has %0d values instead of %0d",
                         line_no, n, NUM_COLS);
                errors++;
            end
        end
    endtask

    initial begin
        int    fd;
        int    line_no;
        bit    at_end;
        string line;

        rst               = 1'b1;
        stall             = 1'b0;
        branch_prediction = 1'b0;
        if_ir             = '0;
        if_pc             = '0;
        if_valid          = 1'b0;
        ex_mem_alu        = '0;
        ex_mem_pcn        = '0;
        ex_mem_pc_mux_sel = lc3b_pc_mux_sel_pc_plus2;
        ex_mem_opcode     = op_add;
        ex_mem_valid      = 1'b0;
        mem_br_en         = 1'b0;
        mem_wb_mdr        = '0;
        mem_wb_pc_mux_sel = lc3b_pc_mux_sel_pc_plus2;
        mem_wb_opcode     = op_add;
        mem_wb_valid      = 1'b0;
        test_name         = "";
        test_cycles       = 0;
        test_errors       = 0;
        tests_run         = 0;
        total_cycles      = 0;
        checks            = 0;
        errors            = 0;
        at_end            = 1'b0;

        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
        end
        #2;
        rst = 1'b0;

        fd = $fopen("tests/branch_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tests/branch_stimulus.txt");
            errors++;
        end else begin
            // line limit bounds the run
            for (line_no = 1; line_no <= MAX_LINES && !at_end; line_no++) begin
                if ($fgets(line, fd) == 0) begin
                    at_end = 1'b1;
                end else begin
                    handle_line(line, line_no);
                end
            end
            $fclose(fd);
            if (!at_end) begin
                $display("stimulus file is longer than %0d lines, reading stopped", MAX_LINES);
                errors++;
            end
        end

        if (test_name != "") begin
            report_test();
        end
        if (total_cycles == 0) begin
            $display("no stimulus cycles were run");
            errors++;
        end

        $display("%0d tests, %0d cycles, %0d checks, %0d errors",
                 tests_run, total_cycles, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : tb_branch_unit

// File: all.f
+incdir+logic
logic/lc3b_types.sv
logic/branch_fetch_decode.sv
logic/branch_waterfall_queue.sv
logic/branch_resolve.sv
logic/branch_controller.sv
logic/branch_unit_top.sv
tests/tb_branch_unit.sv

// File: Makefile
# Verilator build and run of the branch unit testbench

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench, log in sim.log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f all.f --top-module tb_branch_unit -Mdir obj_dir -o sim
	./obj_dir/sim > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Finished with errors" sim.log; then \
		echo "simulation reported errors"; \
		exit 1; \
	fi
	@if ! grep -q "Finished with no errors" sim.log; then \
		echo "simulation ended before the closing report"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: tests/branch_stimulus.txt
# in:  stall pred if_ir if_pc if_v  ex_alu ex_pcn ex_sel ex_op ex_v br_en  wb_mdr wb_sel wb_op wb_v
# out: pc_out pc_plus2 f_active f_if_id f_id_ex f_ex_mem f_mem_wb pred_ok pred_bad
# test reset_idle
0 0 1000 3000 0  0000 0000 0 1 0 0  0000 0 1 0  3002 3002 0 0 0 0 0 0 0
0 0 1000 3002 0  0000 0000 0 1 0 0  0000 0 1 0  3004 3004 0 0 0 0 0 0 0
# test fetch_taken_pos
0 1 0e05 3004 1  0000 0000 0 1 0 0  0000 0 1 0  3010 3006 0 0 0 0 0 0 0
# test fetch_taken_neg
0 1 0ffc 3010 1  0000 0000 0 1 0 0  0000 0 1 0  300a 3012 0 0 0 0 0 0 0
# test fetch_not_taken
0 0 0e20 300a 1  0000 0000 0 1 0 0  0000 0 1 0  300c 300c 0 0 0 0 0 0 0
# test resolve_correct
0 0 1000 300c 0  0000 0000 0 0 1 1  0000 0 1 0  300e 300e 0 0 0 0 0 1 0
# test resolve_mispredict
0 0 1000 300e 0  0000 0000 0 0 1 0  0000 0 1 0  3012 3010 1 1 1 1 0 0 1
# test stall_resolve
0 0 0e03 3012 1  0000 0000 0 1 0 0  0000 0 1 0  3014 3014 0 0 0 0 0 0 0
1 0 1000 3014 0  0000 0000 0 1 0 0  0000 0 1 0  3016 3016 0 0 0 0 0 0 0
0 0 1000 3014 0  0000 0000 0 1 0 0  0000 0 1 0  3016 3016 0 0 0 0 0 0 0
1 0 1000 3016 0  0000 0000 0 1 0 0  0000 0 1 0  3018 3018 0 0 0 0 0 0 0
1 0 1000 3016 0  0000 0000 0 1 0 0  0000 0 1 0  3018 3018 0 0 0 0 0 0 0
0 0 1000 3016 0  0000 0000 0 1 0 0  0000 0 1 0  3018 3018 0 0 0 0 0 0 0
0 0 1000 3018 0  0000 0000 0 0 1 0  0000 0 1 0  301a 301a 0 0 0 0 0 1 0
# test mispredict_not_taken
0 0 0e10 3100 1  0000 0000 0 1 0 0  0000 0 1 0  3102 3102 0 0 0 0 0 0 0
0 0 1000 3102 0  0000 0000 0 1 0 0  0000 0 1 0  3104 3104 0 0 0 0 0 0 0
0 0 1000 3104 0  0000 0000 0 1 0 0  0000 0 1 0  3106 3106 0 0 0 0 0 0 0
0 0 1000 3106 0  0000 0000 0 0 1 1  0000 0 1 0  3122 3108 1 1 1 1 0 0 1
# test jmp_alu
0 0 1000 3122 0  4000 5000 1 c 1 0  0000 0 1 0  4000 3124 1 1 1 1 0 0 0
# test jsr_pcn
0 1 0e05 4000 1  4000 5000 2 4 1 0  0000 0 1 0  5000 4002 1 1 1 1 0 0 0
# test trap_ex
0 0 1000 5000 0  0000 0000 0 f 1 0  0000 0 1 0  5002 5002 1 1 1 1 0 0 0
# test trap_wb
0 1 0e05 5002 1  0000 0000 0 1 0 0  0200 3 f 1  0200 5004 1 1 1 1 1 0 0
0 0 1000 0200 0  0000 0000 0 1 0 0  0000 0 1 0  0202 0202 0 0 0 0 0 0 0
